// File: Makefile
TOOL       = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
TOP        = radio_cmd_core_tb
FILELIST   = radio_cmd_core.f
OBJ_DIR    = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/radio_cmd_core_tb.sv
//------------------------------
// Testbench for the command core: a table of SPI frames run in a loop,
// then a PTT key debounce check. Run through the file list
//------------------------------
`timescale 1ns/10ps
`include "radio_cmd_cfg.svh"

module radio_cmd_core_tb;

  localparam int N_ROWS     = 12;
  localparam int SCK_HALF   = 6;
  localparam int CODEC_WAIT = `CODEC_BITS * 2 * `SCLK_HALF + 4 * `SCLK_HALF + 20;
  localparam int PTT_WAIT   = (`PTT_DEBOUNCE_TICKS + 1) * `QMSEC_CYCLES;

  logic       clk_internal;
  logic       rst_n;
  logic       pi_spi_sck;
  logic       pi_spi_mosi;
  logic       pi_spi_ce;
  logic       io_phone_tip;
  wire        pi_spi_miso;
  wire        io_ptt_out;
  wire  [3:0] channels;
  wire        reset_channels;
  wire        rffe_ad9866_sclk;
  wire        rffe_ad9866_sdio;
  wire        rffe_ad9866_sen_n;

  // Stimulus and expected values, one entry per frame
  logic        row_run [N_ROWS];
  logic        row_ptt [N_ROWS];
  logic [5:0]  row_addr [N_ROWS];
  logic [31:0] row_data [N_ROWS];
  logic        row_key [N_ROWS];
  logic [3:0]  exp_channels [N_ROWS];
  logic        exp_reset [N_ROWS];
  logic [15:0] exp_word [N_ROWS];
  logic        exp_ptt [N_ROWS];
  logic [7:0]  exp_resp [N_ROWS];
  int          row_cnt = 0;

  int          errors = 0;
  int          timeouts = 0;
  integer      seed = 32'hd67d4a3d;

  // Codec port monitor state
  logic [15:0] codec_word = 16'h0000;
  int          codec_bits = 0;
  int          rst_pulses = 0;
  logic        sclk_prev = 1'b0;

  radio_cmd_core radio_cmd_core_i (
    .clk_internal      (clk_internal),
    .rst_n             (rst_n),
    .pi_spi_sck        (pi_spi_sck),
    .pi_spi_mosi       (pi_spi_mosi),
    .pi_spi_ce         (pi_spi_ce),
    .pi_spi_miso       (pi_spi_miso),
    .io_phone_tip      (io_phone_tip),
    .io_ptt_out        (io_ptt_out),
    .channels          (channels),
    .reset_channels    (reset_channels),
    .rffe_ad9866_sclk  (rffe_ad9866_sclk),
    .rffe_ad9866_sdio  (rffe_ad9866_sdio),
    .rffe_ad9866_sen_n (rffe_ad9866_sen_n)
  );

  always #5 clk_internal = ~clk_internal;

  // ------------------------------
  // Monitors, sampled mid-cycle
  // ------------------------------
  always @(negedge clk_internal) begin
    // Codec latches sdio on rising sclk while selected
    if (rffe_ad9866_sclk && !sclk_prev && !rffe_ad9866_sen_n) begin
      codec_word = {codec_word[14:0], rffe_ad9866_sdio};
      codec_bits = codec_bits + 1;
    end
    sclk_prev = rffe_ad9866_sclk;
    if (reset_channels) begin
      rst_pulses = rst_pulses + 1;
    end
  end

  task automatic report_mismatch(input string name, input logic [47:0] got,
                                 input logic [47:0] exp);
    errors = errors + 1;
    $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_internal);
  endtask

  task automatic add_row(input logic run, input logic ptt, input logic [5:0] addr,
                         input logic [31:0] data, input logic key, input logic [3:0] ch,
                         input logic rst, input logic [15:0] word, input logic ptt_out,
                         input logic [7:0] resp);
    row_run[row_cnt]      = run;
    row_ptt[row_cnt]      = ptt;
    row_addr[row_cnt]     = addr;
    row_data[row_cnt]     = data;
    row_key[row_cnt]      = key;
    exp_channels[row_cnt] = ch;
    exp_reset[row_cnt]    = rst;
    exp_word[row_cnt]     = word;
    exp_ptt[row_cnt]      = ptt_out;
    exp_resp[row_cnt]     = resp;
    row_cnt = row_cnt + 1;
  endtask

  // SPI master, mode 0, MSB first; miso read just before each rising sck
  task automatic shift_frame(input logic [47:0] tx, output logic [47:0] rx);
    int i;
    pi_spi_ce = 1'b0;
    wait_cycles(SCK_HALF);
    for (i = `FRAME_BITS - 1; i >= 0; i--) begin
      pi_spi_mosi = tx[i];
      wait_cycles(SCK_HALF);
      rx[i] = pi_spi_miso;
      pi_spi_sck = 1'b1;
      wait_cycles(SCK_HALF);
      pi_spi_sck = 1'b0;
    end
    wait_cycles(SCK_HALF);
    pi_spi_ce   = 1'b1;
    pi_spi_mosi = 1'b0;
    // Room for decode, channel reset and codec select
    wait_cycles(10);
  endtask

  // Status byte, zero pad, then firmware version
  task automatic check_response(input logic [47:0] rx, input logic [7:0] exp);
    if (rx[47:40] !== exp) begin
      report_mismatch("resp", 48'(rx[47:40]), 48'(exp));
    end
    if (rx[39:16] !== 24'd0) begin
      report_mismatch("resp_pad", 48'(rx[39:16]), 48'd0);
    end
    if (rx[15:0] !== {`VERSION_MAJOR, `VERSION_MINOR}) begin
      report_mismatch("version", 48'(rx[15:0]), 48'({`VERSION_MAJOR, `VERSION_MINOR}));
    end
  endtask

  task automatic send_command(input logic run, input logic ptt, input logic [5:0] addr,
                              input logic [31:0] data, input logic [7:0] resp);
    logic [47:0] rx;
    codec_bits = 0;
    codec_word = 16'h0000;
    rst_pulses = 0;
    shift_frame({7'd0, run, 1'b0, addr, ptt, data}, rx);
    check_response(rx, resp);
  endtask

  task automatic wait_codec_idle();
    int cnt;
    cnt = 0;
    while (rffe_ad9866_sen_n !== 1'b1 && cnt < CODEC_WAIT) begin
      @(negedge clk_internal);
      cnt = cnt + 1;
    end
    if (rffe_ad9866_sen_n !== 1'b1) begin
      timeouts = timeouts + 1;
      $display("Codec write did not release sen_n in time");
    end
  endtask

  // Key changes take up to the full debounce time
  task automatic wait_ptt_level(input logic level);
    int cnt;
    cnt = 0;
    while (io_ptt_out !== level && cnt < PTT_WAIT) begin
      @(negedge clk_internal);
      cnt = cnt + 1;
    end
    if (io_ptt_out !== level) begin
      report_mismatch("io_ptt_out", 48'(io_ptt_out), 48'(level));
    end
  endtask

  task automatic apply_row(input int i);
    logic is_codec;
    is_codec = (row_addr[i] == `CMD_ADDR_CODEC);
    send_command(row_run[i], row_ptt[i], row_addr[i], row_data[i], exp_resp[i]);
    io_phone_tip = row_key[i];
    if (is_codec) begin
      wait_codec_idle();
    end
    if (codec_bits !== (is_codec ? 16 : 0)) begin
      report_mismatch("codec_bits", 48'(codec_bits), 48'(is_codec ? 16 : 0));
    end
    if (is_codec && codec_word !== exp_word[i]) begin
      report_mismatch("rffe_ad9866_sdio", 48'(codec_word), 48'(exp_word[i]));
    end
    if (rst_pulses !== int'(exp_reset[i])) begin
      report_mismatch("reset_channels", 48'(rst_pulses), 48'(exp_reset[i]));
    end
    if (channels !== exp_channels[i]) begin
      report_mismatch("channels", 48'(channels), 48'(exp_channels[i]));
    end
    wait_ptt_level(exp_ptt[i]);
  endtask

  initial begin
    int p;
    int k;
    int hold;
    logic rose;
    clk_internal = 1'b0;
    rst_n        = 1'b0;
    pi_spi_sck   = 1'b0;
    pi_spi_mosi  = 1'b0;
    pi_spi_ce    = 1'b1;
    io_phone_tip = 1'b1;

    // ------------------------------
    // Frame table
    // ------------------------------
    // run ptt addr data key | channels reset word ptt_out resp
    add_row(1'b0, 1'b0, 6'h00, 32'h0000_0010, 1'b1, 4'd2, 1'b1, 16'h0000, 1'b0, 8'h00);
    // Same count again
    add_row(1'b0, 1'b0, 6'h00, 32'h0000_0010, 1'b1, 4'd2, 1'b0, 16'h0000, 1'b0, 8'h00);
    add_row(1'b0, 1'b0, 6'h3b, 32'h0000_1234, 1'b1, 4'd2, 1'b0, 16'h1234, 1'b0, 8'h00);
    // Other address, channel bits ignored
    add_row(1'b0, 1'b0, 6'h05, 32'h0000_0078, 1'b1, 4'd2, 1'b0, 16'h0000, 1'b0, 8'h00);
    add_row(1'b1, 1'b1, 6'h00, 32'h0000_0038, 1'b1, 4'd7, 1'b1, 16'h0000, 1'b1, 8'h00);
    add_row(1'b1, 1'b1, 6'h3b, 32'hffff_a5c3, 1'b1, 4'd7, 1'b0, 16'ha5c3, 1'b1, 8'h01);
    // PTT without run stays off
    add_row(1'b0, 1'b1, 6'h00, 32'h0000_0038, 1'b1, 4'd7, 1'b0, 16'h0000, 1'b0, 8'h01);
    add_row(1'b1, 1'b0, 6'h00, 32'h0000_0038, 1'b1, 4'd7, 1'b0, 16'h0000, 1'b0, 8'h00);
    // Key pressed after this frame
    add_row(1'b1, 1'b0, 6'h01, 32'h0000_0000, 1'b0, 4'd7, 1'b0, 16'h0000, 1'b1, 8'h00);
    add_row(1'b1, 1'b0, 6'h00, 32'h0000_0008, 1'b0, 4'd1, 1'b1, 16'h0000, 1'b1, 8'h03);
    add_row(1'b1, 1'b0, 6'h3b, 32'h0000_0001, 1'b1, 4'd1, 1'b0, 16'h0001, 1'b0, 8'h03);
    add_row(1'b0, 1'b0, 6'h00, 32'h0000_0008, 1'b1, 4'd1, 1'b0, 16'h0000, 1'b0, 8'h00);

    wait_cycles(10);
    rst_n = 1'b1;
    wait_cycles(1);

    // Idle values out of reset
    if (rffe_ad9866_sen_n !== 1'b1) begin
      report_mismatch("rffe_ad9866_sen_n", 48'(rffe_ad9866_sen_n), 48'h1);
    end
    if (rffe_ad9866_sclk !== 1'b0) begin
      report_mismatch("rffe_ad9866_sclk", 48'(rffe_ad9866_sclk), 48'h0);
    end
    if (io_ptt_out !== 1'b0) begin
      report_mismatch("io_ptt_out", 48'(io_ptt_out), 48'h0);
    end
    if (channels !== 4'd0) begin
      report_mismatch("channels", 48'(channels), 48'h0);
    end

    for (p = 0; p < N_ROWS; p++) begin
      apply_row(p);
    end

    // ------------------------------
    // Key debounce
    // ------------------------------
    send_command(1'b1, 1'b0, 6'h02, 32'h0000_0000, 8'h00);
    wait_ptt_level(1'b0);
    for (p = 0; p < 4; p++) begin
      hold = 1 + (($random(seed) & 32'h7fff_ffff) % (`QMSEC_CYCLES - 1));
      io_phone_tip = 1'b0;
      wait_cycles(hold);
      io_phone_tip = 1'b1;
      rose = 1'b0;
      for (k = 0; k < PTT_WAIT; k++) begin
        @(negedge clk_internal);
        if (io_ptt_out !== 1'b0) begin
          rose = 1'b1;
        end
      end
      if (rose) begin
        errors = errors + 1;
        $display("Short key press of %0d cycles raised io_ptt_out", hold);
      end
    end

    // Held press must pass the debounce and show in the status byte
    io_phone_tip = 1'b0;
    wait_ptt_level(1'b1);
    wait_cycles(($random(seed) & 32'h7fff_ffff) % `QMSEC_CYCLES);
    send_command(1'b1, 1'b0, 6'h02, 32'h0000_0000, 8'h03);
    io_phone_tip = 1'b1;
    wait_ptt_level(1'b0);
    send_command(1'b1, 1'b0, 6'h02, 32'h0000_0000, 8'h00);
    if (channels !== 4'd1) begin
      report_mismatch("channels", 48'(channels), 48'h1);
    end

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: design/ad9866_ctrl_fsm.sv
//------------------------------
// AD9866 3-wire port master. Takes a codec write request and
// shifts its 16-bit instruction word out MSB first
//------------------------------
`timescale 1ns/10ps
`include "radio_cmd_cfg.svh"

module ad9866_ctrl_fsm
  import radio_cmd_pkg::*;
(
  input  logic       clk_internal,
  input  logic       rst_n,
  input  logic       cmd_rqst,
  input  logic [5:0] cmd_addr,
  input  cmd_data_u  cmd_data,
  output logic       sclk,
  output logic       sdio,
  output logic       sen_n
);

  typedef enum logic [1:0] {
    IDLE,
    SELECT,
    SHIFT,
    RELEASE
  } state_t;

  state_t state;

  logic                   accept;
  logic                   bit_start;
  logic                   sclk_level;
  logic                   shift_strobe;
  logic                   word_done;
  logic [3:0]             bit_idx;
  logic [`CODEC_BITS-1:0] shift_reg;

  // Codec writes only, anything arriving mid-write is dropped
  assign accept    = cmd_rqst && (cmd_addr == `CMD_ADDR_CODEC) && (state == IDLE);
  assign bit_start = accept;

  serial_bit_timer serial_bit_timer_i (
    .clk_internal (clk_internal),
    .rst_n        (rst_n),
    .bit_start    (bit_start),
    .sclk_level   (sclk_level),
    .shift_strobe (shift_strobe),
    .word_done    (word_done),
    .bit_idx      (bit_idx)
  );

  // ------------------------------
  // Sequencing
  // ------------------------------
  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      sen_n <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state <= SELECT;
            sen_n <= 1'b0;
          end
        end
        // Lead halves, wait for first rising sclk
        SELECT: begin
          if (sclk_level) begin
            state <= SHIFT;
          end
        end
        SHIFT: begin
          // Falling edge of bit 0 ends the data phase
          if (shift_strobe && bit_idx == 4'd0) begin
            state <= RELEASE;
          end
        end
        // Tail half with sclk low, then deselect
        RELEASE: begin
          if (word_done) begin
            state <= IDLE;
            sen_n <= 1'b1;
          end
        end
        default: begin
          state <= IDLE;
          sen_n <= 1'b1;
        end
      endcase
    end
  end

  // Data shifter, next bit presented as sclk falls
  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      shift_reg <= '0;
    end else if (accept) begin
      shift_reg <= cmd_data.codec.spi_word;
    end else if (shift_strobe) begin
      shift_reg <= {shift_reg[`CODEC_BITS-2:0], 1'b0};
    end
  end

  assign sdio = shift_reg[`CODEC_BITS-1];
  assign sclk = sclk_level;

endmodule

// File: design/cmd_decoder.sv
//------------------------------
// Turns each received frame into command fields and a request pulse.
// Also holds the receiver channel count and flags count changes
//------------------------------
`timescale 1ns/10ps
`include "radio_cmd_cfg.svh"

module cmd_decoder
  import radio_cmd_pkg::*;
(
  input  logic       clk_internal,
  input  logic       rst_n,
  input  cmd_frame_t frame,
  input  logic       frame_done,
  output logic       run,
  output logic       cmd_ptt,
  output logic       cmd_rqst,
  output logic [5:0] cmd_addr,
  output cmd_data_u  cmd_data,
  output logic [3:0] channels,
  output logic       reset_channels
);

  // Incoming data word, read through the gen view
  cmd_data_u frame_data;
  logic      chan_change;

  assign frame_data = frame.cmd_data;

  // New count only on a general config frame that differs
  assign chan_change = (frame.cmd_addr == `CMD_ADDR_GEN) &&
                       (frame_data.gen.channels != channels);

  // ------------------------------
  // Control levels and pulses
  // ------------------------------
  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      run            <= 1'b0;
      cmd_ptt        <= 1'b0;
      cmd_rqst       <= 1'b0;
      channels       <= 4'd0;
      reset_channels <= 1'b0;
    end else begin
      // Request lines up with the freshly loaded fields
      cmd_rqst       <= frame_done;
      reset_channels <= frame_done && chan_change;
      if (frame_done) begin
        run     <= frame.run;
        cmd_ptt <= frame.cmd_ptt;
        if (chan_change) begin
          channels <= frame_data.gen.channels;
        end
      end
    end
  end

  // Address and data, qualified by cmd_rqst downstream
  always_ff @(posedge clk_internal) begin
    if (frame_done) begin
      cmd_addr <= frame.cmd_addr;
      cmd_data <= frame_data;
    end
  end

endmodule

// File: design/pi_spi_slave.sv
//------------------------------
// SPI slave for the Pi command link, oversampled on clk_internal.
// Receives one 48-bit frame per ce window, returns status and version
//------------------------------
`timescale 1ns/10ps
`include "radio_cmd_cfg.svh"

module pi_spi_slave
  import radio_cmd_pkg::*;
(
  input  logic       clk_internal,
  input  logic       rst_n,
  input  logic       sck,
  input  logic       mosi,
  input  logic       ce,
  output logic       miso,
  input  logic [7:0] resp,
  output cmd_frame_t frame,
  output logic       frame_done
);

  localparam int CNT_W = $clog2(`FRAME_BITS + 1);

  // Two sync flops plus one history flop for edge detect
  logic [2:0] sck_q;
  logic [2:0] ce_q;
  logic [1:0] mosi_q;

  logic sck_rise;
  logic sck_fall;
  logic ce_fall;
  logic ce_rise;
  logic ce_active;

  logic [CNT_W-1:0]      bit_cnt;
  logic [`FRAME_BITS-1:0] rx_shift;
  logic [`FRAME_BITS-1:0] tx_shift;

  // ------------------------------
  // Input synchronizers
  // ------------------------------
  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      sck_q  <= 3'b000;
      ce_q   <= 3'b111;
      mosi_q <= 2'b00;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      ce_q   <= {ce_q[1:0], ce};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  assign sck_rise  = sck_q[1] & ~sck_q[2];
  assign sck_fall  = ~sck_q[1] & sck_q[2];
  assign ce_fall   = ~ce_q[1] & ce_q[2];
  assign ce_rise   = ce_q[1] & ~ce_q[2];
  assign ce_active = ~ce_q[1];

  // ------------------------------
  // Bit count and frame strobe
  // ------------------------------
  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt    <= '0;
      frame_done <= 1'b0;
    end else begin
      // Only an exact-length frame is passed on
      frame_done <= ce_rise && (bit_cnt == CNT_W'(`FRAME_BITS));
      if (ce_fall) begin
        bit_cnt <= '0;
      end else if (sck_rise && ce_active && bit_cnt != '1) begin
        // Saturate so long frames cannot wrap back to 48
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // Receive shift, sampled on rising sck
  always_ff @(posedge clk_internal) begin
    if (sck_rise && ce_active) begin
      rx_shift <= {rx_shift[`FRAME_BITS-2:0], mosi_q[1]};
    end
  end

  // Stable after the last sck edge, so valid with frame_done
  assign frame = rx_shift;

  // Response word, loaded at frame start and moved on falling sck
  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      tx_shift <= '0;
    end else if (ce_fall) begin
      tx_shift <= {resp, 24'h000000, `VERSION_MAJOR, `VERSION_MINOR};
    end else if (sck_fall && ce_active) begin
      tx_shift <= {tx_shift[`FRAME_BITS-2:0], 1'b0};
    end
  end

  assign miso = tx_shift[`FRAME_BITS-1];

endmodule

// File: design/ptt_control.sv
//------------------------------
// Transmit enable from the PTT command and the phone-jack key,
// plus the status byte returned to the Pi
//------------------------------
`timescale 1ns/10ps
`include "radio_cmd_cfg.svh"

module ptt_control (
  input  logic       clk_internal,
  input  logic       rst_n,
  input  logic       run,
  input  logic       cmd_ptt,
  input  logic       io_phone_tip,
  output logic       tx_on,
  output logic [7:0] resp
);

  localparam int TICK_W = $clog2(`QMSEC_CYCLES);
  localparam int DEB_W  = $clog2(`PTT_DEBOUNCE_TICKS + 1);

  logic [TICK_W-1:0] tick_cnt;
  logic              qmsec_tick;
  logic [1:0]        tip_q;
  logic              key_now;
  logic              key_pressed;
  logic [DEB_W-1:0]  deb_cnt;

  // ------------------------------
  // Quarter-millisecond tick
  // ------------------------------
  assign qmsec_tick = (tick_cnt == TICK_W'(`QMSEC_CYCLES - 1));

  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= qmsec_tick ? '0 : tick_cnt + 1'b1;
    end
  end

  // Key is active low, idles high
  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      tip_q <= 2'b11;
    end else begin
      tip_q <= {tip_q[0], io_phone_tip};
    end
  end

  assign key_now = ~tip_q[1];

  // Accept a new key level after it holds for the tick count
  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      key_pressed <= 1'b0;
      deb_cnt     <= '0;
    end else if (key_now == key_pressed) begin
      deb_cnt <= '0;
    end else if (qmsec_tick) begin
      if (deb_cnt == DEB_W'(`PTT_DEBOUNCE_TICKS - 1)) begin
        key_pressed <= key_now;
        deb_cnt     <= '0;
      end else begin
        deb_cnt <= deb_cnt + 1'b1;
      end
    end
  end

  // Transmit only while running
  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      tx_on <= 1'b0;
    end else begin
      tx_on <= run & (cmd_ptt | key_pressed);
    end
  end

  assign resp = {6'b000000, key_pressed, tx_on};

endmodule

// File: design/radio_cmd_cfg.svh
//------------------------------
// Sizes, addresses and timing constants of the command path,
// included by every block that needs one of them
//------------------------------
`ifndef RADIO_CMD_CFG_SVH
`define RADIO_CMD_CFG_SVH

// Pi SPI frame and firmware version
`define FRAME_BITS 48
`define VERSION_MAJOR 8'd72
`define VERSION_MINOR 8'd4

// Command addresses
`define CMD_ADDR_GEN 6'h00
`define CMD_ADDR_CODEC 6'h3b

// Codec serial port, clk_internal cycles per sclk half period
`define SCLK_HALF 4
`define CODEC_BITS 16

// Quarter-ms tick, shortened for simulation
`define QMSEC_CYCLES 25
`define PTT_DEBOUNCE_TICKS 8

`endif

// File: design/radio_cmd_core.sv
//------------------------------
// Command and control core: Pi SPI link, command decode,
// AD9866 register writes and PTT handling
//------------------------------
`timescale 1ns/10ps

module radio_cmd_core
  import radio_cmd_pkg::*;
(
  input  logic       clk_internal,
  input  logic       rst_n,
  // Pi command link
  input  logic       pi_spi_sck,
  input  logic       pi_spi_mosi,
  input  logic       pi_spi_ce,
  output logic       pi_spi_miso,
  // Phone jack and PA switching
  input  logic       io_phone_tip,
  output logic       io_ptt_out,
  // Receiver channel control
  output logic [3:0] channels,
  output logic       reset_channels,
  // Codec serial port
  output logic       rffe_ad9866_sclk,
  output logic       rffe_ad9866_sdio,
  output logic       rffe_ad9866_sen_n
);

  cmd_frame_t frame;
  logic       frame_done;
  logic       run;
  logic       cmd_ptt;
  logic       cmd_rqst;
  logic [5:0] cmd_addr;
  cmd_data_u  cmd_data;
  logic [7:0] resp;

  pi_spi_slave pi_spi_slave_i (
    .clk_internal (clk_internal),
    .rst_n        (rst_n),
    .sck          (pi_spi_sck),
    .mosi         (pi_spi_mosi),
    .ce           (pi_spi_ce),
    .miso         (pi_spi_miso),
    .resp         (resp),
    .frame        (frame),
    .frame_done   (frame_done)
  );

  cmd_decoder cmd_decoder_i (
    .clk_internal   (clk_internal),
    .rst_n          (rst_n),
    .frame          (frame),
    .frame_done     (frame_done),
    .run            (run),
    .cmd_ptt        (cmd_ptt),
    .cmd_rqst       (cmd_rqst),
    .cmd_addr       (cmd_addr),
    .cmd_data       (cmd_data),
    .channels       (channels),
    .reset_channels (reset_channels)
  );

  ad9866_ctrl_fsm ad9866_ctrl_fsm_i (
    .clk_internal (clk_internal),
    .rst_n        (rst_n),
    .cmd_rqst     (cmd_rqst),
    .cmd_addr     (cmd_addr),
    .cmd_data     (cmd_data),
    .sclk         (rffe_ad9866_sclk),
    .sdio         (rffe_ad9866_sdio),
    .sen_n        (rffe_ad9866_sen_n)
  );

  ptt_control ptt_control_i (
    .clk_internal (clk_internal),
    .rst_n        (rst_n),
    .run          (run),
    .cmd_ptt      (cmd_ptt),
    .io_phone_tip (io_phone_tip),
    .tx_on        (io_ptt_out),
    .resp         (resp)
  );

endmodule

// File: design/radio_cmd_pkg.sv
//------------------------------
// Types shared by the command path: the Pi SPI frame and
// the two readings of its 32-bit command data word
//------------------------------
package radio_cmd_pkg;

  // Gen view, valid when cmd_addr is the general config address
  typedef struct packed {
    logic [24:0] rsvd_hi;
    logic [3:0]  channels;
    logic [2:0]  rsvd_lo;
  } gen_cfg_t;

  // Codec view, instruction and value for one AD9866 write
  typedef struct packed {
    logic [15:0] rsvd;
    logic [15:0] spi_word;
  } codec_wr_t;

  // Same 32 bits, decoded by address
  typedef union packed {
    gen_cfg_t  gen;
    codec_wr_t codec;
  } cmd_data_u;

  // 48-bit frame from the Pi, MSB first on the wire
  typedef struct packed {
    logic [6:0]  rsvd_hi;
    logic        run;
    logic        rsvd_mid;
    logic [5:0]  cmd_addr;
    logic        cmd_ptt;
    logic [31:0] cmd_data;
  } cmd_frame_t;

endpackage

// File: design/serial_bit_timer.sv
//------------------------------
// Paces the codec serial clock: two low lead halves, then
// CODEC_BITS full sclk periods, then one low tail half
//------------------------------
`timescale 1ns/10ps
`include "radio_cmd_cfg.svh"

module serial_bit_timer (
  input  logic       clk_internal,
  input  logic       rst_n,
  input  logic       bit_start,
  output logic       sclk_level,
  output logic       shift_strobe,
  output logic       word_done,
  output logic [3:0] bit_idx
);

  localparam int DIV_W = $clog2(`SCLK_HALF);

  logic             active;
  logic             lead_done;
  logic             last_bit;
  logic [DIV_W-1:0] div_cnt;
  logic             half_tick;

  // End of the current half period
  assign half_tick = active && (div_cnt == DIV_W'(`SCLK_HALF - 1));

  // Falling edge, sclk drops on the same clock
  assign shift_strobe = half_tick && sclk_level;
  // Tail half finished after the last bit
  assign word_done = half_tick && !sclk_level && last_bit;

  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      active     <= 1'b0;
      lead_done  <= 1'b0;
      last_bit   <= 1'b0;
      div_cnt    <= '0;
      sclk_level <= 1'b0;
      bit_idx    <= 4'd0;
    end else if (bit_start && !active) begin
      active     <= 1'b1;
      lead_done  <= 1'b0;
      last_bit   <= 1'b0;
      div_cnt    <= '0;
      sclk_level <= 1'b0;
      bit_idx    <= 4'(`CODEC_BITS - 1);
    end else if (active) begin
      div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
      if (half_tick) begin
        if (sclk_level) begin
          sclk_level <= 1'b0;
          // Count down bits, MSB first
          if (bit_idx == 4'd0) begin
            last_bit <= 1'b1;
          end else begin
            bit_idx <= bit_idx - 1'b1;
          end
        end else if (last_bit) begin
          active <= 1'b0;
        end else if (lead_done) begin
          sclk_level <= 1'b1;
        end else begin
          // First lead half over, second stays low
          lead_done <= 1'b1;
        end
      end
    end
  end

endmodule

// File: radio_cmd_core.f
+incdir+design
design/radio_cmd_pkg.sv
design/serial_bit_timer.sv
design/ad9866_ctrl_fsm.sv
design/pi_spi_slave.sv
design/cmd_decoder.sv
design/ptt_control.sv
design/radio_cmd_core.sv
bench/radio_cmd_core_tb.sv
